//--- rv32_pkg.sv
package rv32_pkg;

    // Basic machine types
    typedef logic [31:0] rv32_word;
    typedef logic [4:0]  rv_reg_id_t;

    typedef struct packed {
        logic [6:0] funct7;
        rv_reg_id_t rs2;
        rv_reg_id_t rs1;
        logic [2:0] funct3;
        rv_reg_id_t rd;
        logic [6:0] opcode;
    } rv32_instr_t;

    // Register file depth including x0
    localparam int NUM_REGS = 32;

    // ADDI x0, x0, 0
    localparam rv32_word RV_NOP = 32'h0000_0013;

    // Supported major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Operand source for execute
    typedef enum logic [1:0] {
        BYPASS_NONE,
        BYPASS_DECODED,
        BYPASS_EXEC
    } bypass_t;

    typedef struct packed {
        alu_op_e  alu_op;
        rv32_word imm;
        logic     use_imm;
        logic     pc_src_a;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     is_branch;
        logic     is_jump;
        logic     is_jalr;
        logic     illegal;
        bypass_t  bypass_rs1;
        bypass_t  bypass_rs2;
    } decoded_instr_t;

    // Pipeline buffers
    typedef struct packed {
        rv32_word    pc;
        rv32_instr_t instr;
    } fetch_buffer_data_t;

    typedef struct packed {
        rv32_word       pc;
        rv32_instr_t    instr;
        rv32_word       reg1;
        rv32_word       reg2;
        decoded_instr_t decoded_instr;
    } decoded_buffer_data_t;

    typedef struct packed {
        rv_reg_id_t rd;
        logic       reg_write;
        rv32_word   result;
    } exec_buffer_data_t;

    typedef struct packed {
        logic       en;
        rv_reg_id_t rd;
        rv32_word   data;
    } reg_write_t;

    // Control word of the canonical NOP
    function automatic decoded_instr_t create_nop_ctrl();
        decoded_instr_t ctrl;
        ctrl = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.bypass_rs1 = BYPASS_NONE;
        ctrl.bypass_rs2 = BYPASS_NONE;
        return ctrl;
    endfunction

endpackage

//--- rv32_decoder.sv
module rv32_decoder
    import rv32_pkg::*;
(
    input  rv32_instr_t    instr,
    output decoded_instr_t decoded_instr,
    output logic [1:0]     use_rs
);

    rv32_word imm_i;
    rv32_word imm_s;
    rv32_word imm_b;
    rv32_word imm_u;
    rv32_word imm_j;
    logic     is_reg_op;
    logic     f7_zero;
    logic     f7_alt;
    alu_op_e  arith_op;
    logic     arith_ok;

    // Sign-extended immediates for every format
    assign imm_i = {{21{instr.funct7[6]}}, instr.funct7[5:0], instr.rs2};
    assign imm_s = {{21{instr.funct7[6]}}, instr.funct7[5:0], instr.rd};
    assign imm_b = {{20{instr.funct7[6]}}, instr.rd[0], instr.funct7[5:0],
                    instr.rd[4:1], 1'b0};
    assign imm_u = {instr.funct7, instr.rs2, instr.rs1, instr.funct3, 12'h000};
    assign imm_j = {{12{instr.funct7[6]}}, instr.rs1, instr.funct3, instr.rs2[0],
                    instr.funct7[5:0], instr.rs2[4:1], 1'b0};

    assign is_reg_op = (instr.opcode == OPC_OP);
    assign f7_zero = (instr.funct7 == 7'b0000000);
    assign f7_alt = (instr.funct7 == 7'b0100000);

    // ALU operation shared by OP and OP-IMM
    always_comb begin
        arith_ok = !is_reg_op || f7_zero;
        case (instr.funct3)
            3'b000: begin
                arith_op = (is_reg_op && f7_alt) ? ALU_SUB : ALU_ADD;
                arith_ok = !is_reg_op || f7_zero || f7_alt;
            end
            3'b001: begin
                arith_op = ALU_SLL;
                arith_ok = f7_zero;
            end
            3'b010: arith_op = ALU_SLT;
            3'b011: arith_op = ALU_SLTU;
            3'b100: arith_op = ALU_XOR;
            3'b101: begin
                arith_op = f7_alt ? ALU_SRA : ALU_SRL;
                arith_ok = f7_zero || f7_alt;
            end
            3'b110: arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        decoded_instr = create_nop_ctrl();
        use_rs = 2'b00;
        case (rv_opcode_e'(instr.opcode))
            OPC_LUI: begin
                decoded_instr.alu_op = ALU_PASS_B;
                decoded_instr.imm = imm_u;
                decoded_instr.use_imm = 1'b1;
                decoded_instr.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                decoded_instr.imm = imm_u;
                decoded_instr.use_imm = 1'b1;
                decoded_instr.pc_src_a = 1'b1;
                decoded_instr.reg_write = 1'b1;
            end
            OPC_JAL: begin
                decoded_instr.imm = imm_j;
                decoded_instr.pc_src_a = 1'b1;
                decoded_instr.reg_write = 1'b1;
                decoded_instr.is_jump = 1'b1;
            end
            OPC_JALR: begin
                decoded_instr.imm = imm_i;
                decoded_instr.use_imm = 1'b1;
                decoded_instr.reg_write = 1'b1;
                decoded_instr.is_jump = 1'b1;
                decoded_instr.is_jalr = 1'b1;
                decoded_instr.illegal = (instr.funct3 != 3'b000);
                use_rs = 2'b01;
            end
            OPC_BRANCH: begin
                // Compare type picked from funct3[2:1]
                decoded_instr.alu_op = instr.funct3[2] ?
                    (instr.funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
                decoded_instr.imm = imm_b;
                decoded_instr.is_branch = 1'b1;
                decoded_instr.illegal = (instr.funct3[2:1] == 2'b01);
                use_rs = 2'b11;
            end
            OPC_LOAD: begin
                decoded_instr.imm = imm_i;
                decoded_instr.use_imm = 1'b1;
                decoded_instr.reg_write = 1'b1;
                decoded_instr.mem_read = 1'b1;
                decoded_instr.illegal = (instr.funct3 == 3'b011) || (instr.funct3[2:1] == 2'b11);
                use_rs = 2'b01;
            end
            OPC_STORE: begin
                decoded_instr.imm = imm_s;
                decoded_instr.use_imm = 1'b1;
                decoded_instr.mem_write = 1'b1;
                decoded_instr.illegal = instr.funct3[2] || (instr.funct3[1:0] == 2'b11);
                use_rs = 2'b11;
            end
            OPC_OP_IMM: begin
                decoded_instr.alu_op = arith_op;
                decoded_instr.imm = imm_i;
                decoded_instr.use_imm = 1'b1;
                decoded_instr.reg_write = 1'b1;
                decoded_instr.illegal = !arith_ok;
                use_rs = 2'b01;
            end
            OPC_OP: begin
                decoded_instr.alu_op = arith_op;
                decoded_instr.reg_write = 1'b1;
                decoded_instr.illegal = !arith_ok;
                use_rs = 2'b11;
            end
            default: decoded_instr.illegal = 1'b1;
        endcase

        // Illegal encodings read nothing, so they cannot stall
        if (decoded_instr.illegal) begin
            use_rs = 2'b00;
        end
    end

endmodule

//--- rv32_hazard_unit.sv
module rv32_hazard_unit
    import rv32_pkg::*;
(
    input  logic [1:0]           use_rs,
    input  rv32_instr_t          current_instr,
    input  decoded_buffer_data_t decoded_buff,
    input  exec_buffer_data_t    exec_buff,
    output logic                 stall,
    output bypass_t              bypass_rs [2]
);

    rv_reg_id_t src [2];
    rv_reg_id_t dec_rd;
    logic       dec_load;
    logic       dec_write;

    assign src[0] = current_instr.rs1;
    assign src[1] = current_instr.rs2;

    // Producer currently in execute
    assign dec_rd = decoded_buff.instr.rd;
    assign dec_load = decoded_buff.decoded_instr.mem_read;
    assign dec_write = decoded_buff.decoded_instr.reg_write;

    always_comb begin
        stall = 1'b0;
        for (int i = 0; i < 2; i++) begin
            bypass_rs[i] = BYPASS_NONE;
            if (use_rs[i] && (src[i] != '0)) begin
                // Youngest producer takes priority
                if (dec_load && (dec_rd == src[i])) begin
                    // Load data is not ready until memory stage
                    stall = 1'b1;
                end else if (dec_write && (dec_rd == src[i])) begin
                    bypass_rs[i] = BYPASS_DECODED;
                end else if (exec_buff.reg_write && (exec_buff.rd == src[i])) begin
                    bypass_rs[i] = BYPASS_EXEC;
                end
            end
        end
    end

endmodule

//--- rv32_regfile.sv
module rv32_regfile
    import rv32_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  rv_reg_id_t rs1,
    input  rv_reg_id_t rs2,
    output rv32_word   reg1,
    output rv32_word   reg2,
    input  reg_write_t wb
);

    // x0 has no storage
    rv32_word regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Write-through so writeback data reaches decode in the same cycle
    always_comb begin
        reg1 = '0;
        reg2 = '0;
        if (rs1 != '0) begin
            reg1 = (wb.en && (wb.rd == rs1)) ? wb.data : regs[rs1];
        end
        if (rs2 != '0) begin
            reg2 = (wb.en && (wb.rd == rs2)) ? wb.data : regs[rs2];
        end
    end

endmodule

//--- rv32_decode_stage.sv
module rv32_decode_stage
    import rv32_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 set_nop,
    input  logic                 stop,
    input  rv32_word             set_nop_pc,
    input  fetch_buffer_data_t   instr_data,
    output decoded_buffer_data_t decode_data,
    output logic                 stall,
    output rv_reg_id_t           rs1,
    output rv_reg_id_t           rs2,
    input  rv32_word             reg1,
    input  rv32_word             reg2,
    input  exec_buffer_data_t    exec_buff
);

    decoded_instr_t       dec_ctrl;
    logic [1:0]           use_rs;
    bypass_t              bypass_rs [2];
    decoded_buffer_data_t next_entry;

    rv32_decoder decoder_i (
        .instr         (instr_data.instr),
        .decoded_instr (dec_ctrl),
        .use_rs        (use_rs)
    );

    rv32_hazard_unit hazard_i (
        .use_rs        (use_rs),
        .current_instr (instr_data.instr),
        .decoded_buff  (decode_data),
        .exec_buff     (exec_buff),
        .stall         (stall),
        .bypass_rs     (bypass_rs)
    );

    assign rs1 = instr_data.instr.rs1;
    assign rs2 = instr_data.instr.rs2;

    always_comb begin
        next_entry.pc = instr_data.pc;
        next_entry.instr = instr_data.instr;
        next_entry.reg1 = reg1;
        next_entry.reg2 = reg2;
        next_entry.decoded_instr = dec_ctrl;
        next_entry.decoded_instr.bypass_rs1 = bypass_rs[0];
        next_entry.decoded_instr.bypass_rs2 = bypass_rs[1];

        // Bubble keeps the pc of the slot it replaces
        if (stall || set_nop || dec_ctrl.illegal) begin
            next_entry.instr = rv32_instr_t'(RV_NOP);
            next_entry.reg1 = '0;
            next_entry.reg2 = '0;
            next_entry.decoded_instr = create_nop_ctrl();
            if (set_nop) begin
                next_entry.pc = set_nop_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            decode_data.pc <= '0;
            decode_data.instr <= rv32_instr_t'(RV_NOP);
            decode_data.reg1 <= '0;
            decode_data.reg2 <= '0;
            decode_data.decoded_instr <= create_nop_ctrl();
        end else if (!stop) begin
            decode_data <= next_entry;
        end
    end

endmodule

//--- rv32_decode_top.sv
module rv32_decode_top
    import rv32_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 set_nop,
    input  logic                 stop,
    input  rv32_word             set_nop_pc,
    input  fetch_buffer_data_t   instr_data,
    input  exec_buffer_data_t    exec_buff,
    input  reg_write_t           wb,
    output decoded_buffer_data_t decode_data,
    output logic                 stall
);

    // Register file read path
    rv_reg_id_t rs1;
    rv_reg_id_t rs2;
    rv32_word   reg1;
    rv32_word   reg2;

    rv32_regfile regfile_i (
        .clk    (clk),
        .resetn (resetn),
        .rs1    (rs1),
        .rs2    (rs2),
        .reg1   (reg1),
        .reg2   (reg2),
        .wb     (wb)
    );

    rv32_decode_stage decode_stage_i (
        .clk         (clk),
        .resetn      (resetn),
        .set_nop     (set_nop),
        .stop        (stop),
        .set_nop_pc  (set_nop_pc),
        .instr_data  (instr_data),
        .decode_data (decode_data),
        .stall       (stall),
        .rs1         (rs1),
        .rs2         (rs2),
        .reg1        (reg1),
        .reg2        (reg2),
        .exec_buff   (exec_buff)
    );

endmodule

//--- rv32_decode_top_tb.sv
module rv32_decode_top_tb
    import rv32_pkg::*;
();

    // One table row holds stimulus for one cycle and the entry expected after it
    typedef struct packed {
        fetch_buffer_data_t fetch;
        logic               bubble;
        logic               set_nop;
        logic               stop;
        exec_buffer_data_t  exec;
        reg_write_t         wr_port;
        decoded_instr_t     exp_ctrl;
        rv32_word           exp_reg1;
        rv32_word           exp_reg2;
        logic               exp_stall;
    } row_t;

    logic                 clk = 1'b0;
    logic                 resetn;
    logic                 set_nop;
    logic                 stop;
    rv32_word             set_nop_pc;
    fetch_buffer_data_t   instr_data;
    exec_buffer_data_t    exec_buff;
    reg_write_t           wb;
    decoded_buffer_data_t decode_data;
    logic                 stall;

    row_t  rows [$];
    string names [$];

    always #20 clk = ~clk;

    rv32_decode_top rv32_decode_top_i (
        .clk         (clk),
        .resetn      (resetn),
        .set_nop     (set_nop),
        .stop        (stop),
        .set_nop_pc  (set_nop_pc),
        .instr_data  (instr_data),
        .exec_buff   (exec_buff),
        .wb          (wb),
        .decode_data (decode_data),
        .stall       (stall)
    );

    task automatic check(input string name, input logic [63:0] exp_val,
            input logic [63:0] act_val);
        if (exp_val !== act_val) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp_val, act_val);
            $display("Test failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_entry(input string name, input decoded_buffer_data_t exp_entry);
        check({name, ".pc"}, 64'(exp_entry.pc), 64'(decode_data.pc));
        check({name, ".instr"}, 64'(exp_entry.instr), 64'(decode_data.instr));
        check({name, ".reg1"}, 64'(exp_entry.reg1), 64'(decode_data.reg1));
        check({name, ".reg2"}, 64'(exp_entry.reg2), 64'(decode_data.reg2));
        check({name, ".ctrl"}, 64'(exp_entry.decoded_instr), 64'(decode_data.decoded_instr));
    endtask

    // Flag bits in order use_imm pc_src_a reg_write mem_read mem_write is_branch
    // is_jump is_jalr illegal
    function automatic decoded_instr_t ctrl(input alu_op_e op, input rv32_word imm,
            input logic [8:0] flags, input bypass_t b1, input bypass_t b2);
        decoded_instr_t c;
        c.alu_op = op;
        c.imm = imm;
        {c.use_imm, c.pc_src_a, c.reg_write, c.mem_read, c.mem_write,
         c.is_branch, c.is_jump, c.is_jalr, c.illegal} = flags;
        c.bypass_rs1 = b1;
        c.bypass_rs2 = b2;
        return c;
    endfunction

    function automatic decoded_instr_t bubble_ctrl();
        return ctrl(ALU_ADD, '0, '0, BYPASS_NONE, BYPASS_NONE);
    endfunction

    function automatic exec_buffer_data_t ex(input rv_reg_id_t rd);
        exec_buffer_data_t e;
        e.rd = rd;
        e.reg_write = 1'b1;
        e.result = 32'hA5A5_A5A5;
        return e;
    endfunction

    function automatic reg_write_t wr(input rv_reg_id_t rd, input rv32_word data);
        reg_write_t w;
        w.en = 1'b1;
        w.rd = rd;
        w.data = data;
        return w;
    endfunction

    // ctl is {bubble, set_nop, stop}
    task automatic add_row(input string name, input rv32_word instr, input rv32_word pc,
            input logic [2:0] ctl, input exec_buffer_data_t exec, input reg_write_t wr_port,
            input decoded_instr_t exp_ctrl, input rv32_word r1, input rv32_word r2,
            input logic exp_stall);
        row_t r;
        r.fetch.pc = pc;
        r.fetch.instr = instr;
        {r.bubble, r.set_nop, r.stop} = ctl;
        r.exec = exec;
        r.wr_port = wr_port;
        r.exp_ctrl = exp_ctrl;
        r.exp_reg1 = r1;
        r.exp_reg2 = r2;
        r.exp_stall = exp_stall;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic build_table();
        // Register writes through the writeback port
        add_row("wb_x1", 32'h0000_0013, 32'h100, 3'b000, '0, wr(5'd1, 32'h0000_1111),
            ctrl(ALU_ADD, '0, 9'b101000000, BYPASS_NONE, BYPASS_NONE), '0, '0, 1'b0);
        add_row("wb_x2", 32'h0000_0013, 32'h104, 3'b000, '0, wr(5'd2, 32'h0000_2222),
            ctrl(ALU_ADD, '0, 9'b101000000, BYPASS_NONE, BYPASS_NONE), '0, '0, 1'b0);
        add_row("wb_x0", 32'h0000_0013, 32'h108, 3'b000, '0, wr(5'd0, 32'hDEAD_BEEF),
            ctrl(ALU_ADD, '0, 9'b101000000, BYPASS_NONE, BYPASS_NONE), '0, '0, 1'b0);
        add_row("read_regs", 32'h0020_8233, 32'h10C, 3'b000, '0, '0,
            ctrl(ALU_ADD, '0, 9'b001000000, BYPASS_NONE, BYPASS_NONE),
            32'h1111, 32'h2222, 1'b0);
        add_row("write_through", 32'h4030_02B3, 32'h110, 3'b000, '0, wr(5'd3, 32'h3333_3333),
            ctrl(ALU_SUB, '0, 9'b001000000, BYPASS_NONE, BYPASS_NONE), '0, 32'h3333_3333, 1'b0);
        add_row("addi_neg", 32'hFFF0_0313, 32'h114, 3'b000, '0, '0,
            ctrl(ALU_ADD, 32'hFFFF_FFFF, 9'b101000000, BYPASS_NONE, BYPASS_NONE), '0, '0, 1'b0);

        // Bypass selection
        add_row("bypass_decoded", 32'h0013_03B3, 32'h118, 3'b000, '0, '0,
            ctrl(ALU_ADD, '0, 9'b001000000, BYPASS_DECODED, BYPASS_NONE), '0, 32'h1111, 1'b0);
        add_row("bypass_exec", 32'h0091_4433, 32'h11C, 3'b000, ex(5'd9), '0,
            ctrl(ALU_XOR, '0, 9'b001000000, BYPASS_NONE, BYPASS_EXEC), 32'h2222, '0, 1'b0);
        add_row("bypass_priority", 32'h0094_6533, 32'h120, 3'b000, ex(5'd8), '0,
            ctrl(ALU_OR, '0, 9'b001000000, BYPASS_DECODED, BYPASS_NONE), '0, '0, 1'b0);
        add_row("lui_unused", 32'h1235_05B7, 32'h124, 3'b000, ex(5'd3), '0,
            ctrl(ALU_PASS_B, 32'h1235_0000, 9'b101000000, BYPASS_NONE, BYPASS_NONE),
            '0, 32'h3333_3333, 1'b0);
        add_row("load_x0", 32'h0040_A003, 32'h128, 3'b000, '0, '0,
            ctrl(ALU_ADD, 32'h4, 9'b101100000, BYPASS_NONE, BYPASS_NONE), 32'h1111, '0, 1'b0);
        add_row("x0_no_match", 32'h0000_0633, 32'h12C, 3'b000, ex(5'd0), '0,
            ctrl(ALU_ADD, '0, 9'b001000000, BYPASS_NONE, BYPASS_NONE), '0, '0, 1'b0);

        // Load-use stall while fetch holds the dependent instruction
        add_row("load", 32'h0001_2683, 32'h130, 3'b000, '0, '0,
            ctrl(ALU_ADD, '0, 9'b101100000, BYPASS_NONE, BYPASS_NONE), 32'h2222, '0, 1'b0);
        add_row("load_use", 32'h0016_8733, 32'h134, 3'b100, '0, '0,
            bubble_ctrl(), '0, '0, 1'b1);
        add_row("after_stall", 32'h0016_8733, 32'h134, 3'b000, ex(5'd13), '0,
            ctrl(ALU_ADD, '0, 9'b001000000, BYPASS_EXEC, BYPASS_NONE), '0, 32'h1111, 1'b0);

        // Remaining opcodes
        add_row("auipc", 32'hFFFF_F797, 32'h138, 3'b000, '0, '0,
            ctrl(ALU_ADD, 32'hFFFF_F000, 9'b111000000, BYPASS_NONE, BYPASS_NONE), '0, '0, 1'b0);
        add_row("jal", 32'hFF9F_F0EF, 32'h13C, 3'b000, '0, '0,
            ctrl(ALU_ADD, 32'hFFFF_FFF8, 9'b011000100, BYPASS_NONE, BYPASS_NONE), '0, '0, 1'b0);
        add_row("jalr", 32'hFFC0_82E7, 32'h140, 3'b000, '0, '0,
            ctrl(ALU_ADD, 32'hFFFF_FFFC, 9'b101000110, BYPASS_DECODED, BYPASS_NONE),
            32'h1111, '0, 1'b0);
        add_row("bne", 32'hFE20_98E3, 32'h144, 3'b000, '0, '0,
            ctrl(ALU_SUB, 32'hFFFF_FFF0, 9'b000001000, BYPASS_NONE, BYPASS_NONE),
            32'h1111, 32'h2222, 1'b0);
        add_row("sw", 32'hFE20_AE23, 32'h148, 3'b000, '0, '0,
            ctrl(ALU_ADD, 32'hFFFF_FFFC, 9'b100010000, BYPASS_NONE, BYPASS_NONE),
            32'h1111, 32'h2222, 1'b0);
        add_row("srai", 32'h4031_5813, 32'h14C, 3'b000, '0, '0,
            ctrl(ALU_SRA, 32'h403, 9'b101000000, BYPASS_NONE, BYPASS_NONE),
            32'h2222, 32'h3333_3333, 1'b0);
        add_row("illegal_mul", 32'h0220_8833, 32'h150, 3'b100, '0, '0,
            bubble_ctrl(), '0, '0, 1'b0);
        add_row("illegal_ecall", 32'h0000_0073, 32'h154, 3'b100, '0, '0,
            bubble_ctrl(), '0, '0, 1'b0);

        // Pipeline control
        add_row("set_nop", 32'h0020_8233, 32'h158, 3'b110, '0, '0,
            bubble_ctrl(), '0, '0, 1'b0);
        add_row("stop_load", 32'h0020_8233, 32'h15C, 3'b000, '0, '0,
            ctrl(ALU_ADD, '0, 9'b001000000, BYPASS_NONE, BYPASS_NONE),
            32'h1111, 32'h2222, 1'b0);
        add_row("stop_hold_1", 32'h4030_02B3, 32'h160, 3'b001, '0, '0,
            bubble_ctrl(), '0, '0, 1'b0);
        add_row("stop_hold_2", 32'h4030_02B3, 32'h160, 3'b001, '0, '0,
            bubble_ctrl(), '0, '0, 1'b0);
        add_row("stop_hold_3", 32'h4030_02B3, 32'h160, 3'b001, '0, '0,
            bubble_ctrl(), '0, '0, 1'b0);
        add_row("resume", 32'h4030_02B3, 32'h160, 3'b000, '0, '0,
            ctrl(ALU_SUB, '0, 9'b001000000, BYPASS_NONE, BYPASS_NONE), '0, 32'h3333_3333, 1'b0);
    endtask

    initial begin
        decoded_buffer_data_t expected;
        int cycles;

        resetn = 1'b0;
        set_nop = 1'b0;
        stop = 1'b0;
        set_nop_pc = 32'h0000_0800;
        instr_data.pc = '0;
        instr_data.instr = 32'h0000_0013;
        exec_buff = '0;
        wb = '0;
        build_table();

        for (cycles = 0; cycles < 8; cycles++) begin
            @(posedge clk);
        end
        #2;
        resetn = 1'b1;
        #1;

        // Reset entry is ADDI x0,x0,0 with an all-clear control word
        expected.pc = '0;
        expected.instr = 32'h0000_0013;
        expected.reg1 = '0;
        expected.reg2 = '0;
        expected.decoded_instr = bubble_ctrl();
        check_entry("reset", expected);
        check("reset.stall", 64'(1'b0), 64'(stall));

        @(posedge clk);
        #2;
        foreach (rows[i]) begin
            set_nop = rows[i].set_nop;
            stop = rows[i].stop;
            instr_data = rows[i].fetch;
            exec_buff = rows[i].exec;
            wb = rows[i].wr_port;
            #1;
            check({names[i], ".stall"}, 64'(rows[i].exp_stall), 64'(stall));

            // Stop keeps the previous expected entry
            if (!rows[i].stop) begin
                expected.pc = rows[i].set_nop ? set_nop_pc : rows[i].fetch.pc;
                if (rows[i].bubble) begin
                    expected.instr = 32'h0000_0013;
                end else begin
                    expected.instr = rows[i].fetch.instr;
                end
                expected.reg1 = rows[i].exp_reg1;
                expected.reg2 = rows[i].exp_reg2;
                expected.decoded_instr = rows[i].exp_ctrl;
            end

            @(posedge clk);
            #2;
            check_entry(names[i], expected);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- rv32_decode_top.f
rv32_pkg.sv
rv32_decoder.sv
rv32_hazard_unit.sv
rv32_regfile.sv
rv32_decode_stage.sv
rv32_decode_top.sv
rv32_decode_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f rv32_decode_top.f --top-module rv32_decode_top_tb \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
